// File: Makefile
VERILATOR ?= verilator
TOP ?= lsu_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
SB_DEPTH ?= 2
MEM_WORDS ?= 64
VFLAGS ?= --binary --timing --assert -j 0
PARAMS = -GSB_DEPTH=$(SB_DEPTH) -GMEM_WORDS=$(MEM_WORDS)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(PARAMS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing $(PARAMS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: lsu_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_gen import lsu_pkg::*; (
    input wire mem_op_t i_op,
    input wire xword_t i_src0,
    input wire xword_t i_src1,
    output xword_t o_addr,
    output byte_mask_t o_mask,
    output logic o_misaligned,
    output logic o_is_store,
    output logic o_is_load
);

    byte_mask_t base_mask;
    // access size minus one, doubles as the alignment mask
    logic [2:0] size_m1;

    assign o_addr = i_src0 + i_src1;

    always_comb begin
        base_mask = 8'hff;
        size_m1 = 3'd7;
        o_is_store = 1'b0;
        o_is_load = 1'b0;
        case (i_op)
            lb, lbu: begin
                base_mask = 8'h01;
                size_m1 = 3'd0;
                o_is_load = 1'b1;
            end
            lh, lhu: begin
                base_mask = 8'h03;
                size_m1 = 3'd1;
                o_is_load = 1'b1;
            end
            lw, lwu: begin
                base_mask = 8'h0f;
                size_m1 = 3'd3;
                o_is_load = 1'b1;
            end
            ld: begin
                o_is_load = 1'b1;
            end
            sb: begin
                base_mask = 8'h01;
                size_m1 = 3'd0;
                o_is_store = 1'b1;
            end
            sh: begin
                base_mask = 8'h03;
                size_m1 = 3'd1;
                o_is_store = 1'b1;
            end
            sw: begin
                base_mask = 8'h0f;
                size_m1 = 3'd3;
                o_is_store = 1'b1;
            end
            sd: begin
                o_is_store = 1'b1;
            end
            default: begin
                base_mask = 8'h00;
            end
        endcase
    end

    // bytes past the doubleword only fall off for misaligned ops
    assign o_mask = base_mask << o_addr[2:0];
    assign o_misaligned = (o_addr[2:0] & size_m1) != 3'd0;

endmodule

`default_nettype wire

// File: lsu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_checker #(
    parameter int SB_DEPTH = 4
) (
    input wire clk,
    input wire rst,
    input wire i_wb_vld,
    input wire i_rd_en,
    input wire i_push,
    input wire [$clog2(SB_DEPTH+1)-1:0] i_sb_count
);

    localparam int CW = $clog2(SB_DEPTH+1);

    // nothing can be in flight right out of reset
    wb_quiet_after_reset: assert property (@(posedge clk) $fell(rst) |=> !i_wb_vld)
        else $error("writeback valid in the cycle after reset");

    // one ram port, shared by load reads and buffer drain
    // a load in s1 pushes nothing, so the count only moves on a drain
    ram_port_exclusive: assert property (@(posedge clk) disable iff (rst)
        i_rd_en |=> (i_sb_count == $past(i_sb_count)))
        else $error("store buffer drained while a load read the ram");

    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        i_push |-> (i_sb_count < CW'(SB_DEPTH)))
        else $error("store pushed into a full store buffer");

endmodule

bind lsu_load_pipe lsu_checker #(
    .SB_DEPTH(SB_DEPTH)
) u_checker (
    .clk(clk),
    .rst(rst),
    .i_wb_vld(o_wb_vld),
    .i_rd_en(o_rd_en),
    .i_push(o_push),
    .i_sb_count(i_sb_count)
);

`default_nettype wire

// File: lsu_data_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_data_align import lsu_pkg::*; (
    input wire mem_op_t i_op,
    input wire [2:0] i_addr_low,
    input wire xword_t i_ram_data,
    input wire byte_mask_t i_fwd_mask,
    input wire xword_t i_fwd_data,
    output xword_t o_result
);

    xword_t merged;
    xword_t shifted;

    // forwarded bytes win over the ram bytes
    always_comb begin
        for (int b = 0; b < xbytes; b++) begin
            merged[8*b +: 8] = i_fwd_mask[b] ? i_fwd_data[8*b +: 8] : i_ram_data[8*b +: 8];
        end
    end

    assign shifted = merged >> {i_addr_low, 3'b000};

    always_comb begin
        case (i_op)
            lb: o_result = {{56{shifted[7]}}, shifted[7:0]};
            lh: o_result = {{48{shifted[15]}}, shifted[15:0]};
            lw: o_result = {{32{shifted[31]}}, shifted[31:0]};
            ld: o_result = shifted;
            lbu: o_result = {56'd0, shifted[7:0]};
            lhu: o_result = {48'd0, shifted[15:0]};
            lwu: o_result = {32'd0, shifted[31:0]};
            // stores return nothing
            default: o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: lsu_dcache_ram.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_dcache_ram import lsu_pkg::*; #(
    parameter int MEM_WORDS = 64
) (
    input wire clk,
    input wire rst,
    input wire i_rd_en,
    input wire xword_t i_rd_addr,
    input wire i_wr_en,
    input wire xword_t i_wr_addr,
    input wire byte_mask_t i_wr_mask,
    input wire xword_t i_wr_data,
    output xword_t o_rd_data,
    output logic o_clear_done
);

    localparam int AW = $clog2(MEM_WORDS);

    xword_t mem [MEM_WORDS];
    logic [AW-1:0] clr_idx;

    // zero one word per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_idx <= '0;
            o_clear_done <= 1'b0;
        end else if (!o_clear_done) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == AW'(MEM_WORDS - 1)) begin
                o_clear_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!o_clear_done) begin
            mem[clr_idx] <= '0;
        end else if (i_wr_en) begin
            for (int b = 0; b < xbytes; b++) begin
                if (i_wr_mask[b]) begin
                    mem[i_wr_addr[3 +: AW]][8*b +: 8] <= i_wr_data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr[3 +: AW]];
        end
    end

endmodule

`default_nettype wire

// File: lsu_load_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_pipe import lsu_pkg::*; #(
    parameter int SB_DEPTH = 4
) (
    input wire clk,
    input wire rst,
    input wire i_vld,
    input wire mem_op_t i_op,
    input wire xword_t i_src0,
    input wire xword_t i_src1,
    input wire xword_t i_st_data,
    input wire rob_idx_t i_rob_idx,
    input wire [$clog2(SB_DEPTH+1)-1:0] i_sb_count,
    input wire xword_t i_ram_data,
    input wire byte_mask_t i_fwd_mask,
    input wire xword_t i_fwd_data,
    input wire i_clear_done,
    output logic o_stall,
    output logic o_push,
    output xword_t o_push_addr,
    output byte_mask_t o_push_mask,
    output xword_t o_push_data,
    output xword_t o_lookup_addr,
    output logic o_rd_en,
    output xword_t o_rd_addr,
    output logic o_drain_en,
    output logic o_wb_vld,
    output rob_idx_t o_wb_rob_idx,
    output xword_t o_wb_data,
    output logic o_wb_misaligned
);

    localparam int CW = $clog2(SB_DEPTH+1);

    // s0 address stage
    logic s0_vld;
    mem_op_t s0_op;
    xword_t s0_src0;
    xword_t s0_src1;
    xword_t s0_st_data;
    rob_idx_t s0_rob;
    xword_t s0_addr;
    byte_mask_t s0_mask;
    logic s0_mis;
    logic s0_is_store;
    logic s0_is_load;

    // s1 lookup stage
    logic s1_vld;
    mem_op_t s1_op;
    xword_t s1_addr;
    byte_mask_t s1_mask;
    logic s1_mis;
    logic s1_is_store;
    logic s1_is_load;
    xword_t s1_st_data;
    rob_idx_t s1_rob;
    logic s1_ld_go;

    // s2 data select stage
    logic s2_vld;
    mem_op_t s2_op;
    logic [2:0] s2_addr_low;
    logic s2_mis;
    logic s2_is_load;
    byte_mask_t s2_fwd_mask;
    xword_t s2_fwd_data;
    rob_idx_t s2_rob;
    xword_t s2_result;

    logic [CW:0] occupancy;

    // stores not yet drained, counting those still in flight
    assign occupancy = (CW+1)'(i_sb_count) + (CW+1)'(s0_vld && s0_is_store)
                     + (CW+1)'(s1_vld && s1_is_store);
    assign o_stall = !i_clear_done || (occupancy >= (CW+1)'(SB_DEPTH));

    always_ff @(posedge clk) begin
        if (rst) begin
            s0_vld <= 1'b0;
        end else begin
            s0_vld <= i_vld && !o_stall;
        end
    end

    always_ff @(posedge clk) begin
        if (i_vld && !o_stall) begin
            s0_op <= i_op;
            s0_src0 <= i_src0;
            s0_src1 <= i_src1;
            s0_st_data <= i_st_data;
            s0_rob <= i_rob_idx;
        end
    end

    lsu_addr_gen u_addr_gen (
        .i_op(s0_op),
        .i_src0(s0_src0),
        .i_src1(s0_src1),
        .o_addr(s0_addr),
        .o_mask(s0_mask),
        .o_misaligned(s0_mis),
        .o_is_store(s0_is_store),
        .o_is_load(s0_is_load)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= s0_vld;
        end
        s1_op <= s0_op;
        s1_addr <= s0_addr;
        s1_mask <= s0_mask;
        s1_mis <= s0_mis;
        s1_is_store <= s0_is_store;
        s1_is_load <= s0_is_load;
        // store bytes moved to their lanes in the doubleword
        s1_st_data <= s0_st_data << {s0_addr[2:0], 3'b000};
        s1_rob <= s0_rob;
    end

    assign s1_ld_go = s1_vld && s1_is_load && !s1_mis;

    assign o_push = s1_vld && s1_is_store && !s1_mis;
    assign o_push_addr = s1_addr;
    assign o_push_mask = s1_mask;
    assign o_push_data = s1_st_data;
    assign o_lookup_addr = s1_addr;

    // load owns the ram port, otherwise the buffer may drain
    assign o_rd_en = s1_ld_go;
    assign o_rd_addr = s1_addr;
    assign o_drain_en = !s1_ld_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_vld <= 1'b0;
        end else begin
            s2_vld <= s1_vld;
        end
        s2_op <= s1_op;
        s2_addr_low <= s1_addr[2:0];
        s2_mis <= s1_mis;
        s2_is_load <= s1_is_load;
        s2_fwd_mask <= i_fwd_mask;
        s2_fwd_data <= i_fwd_data;
        s2_rob <= s1_rob;
    end

    lsu_data_align u_data_align (
        .i_op(s2_op),
        .i_addr_low(s2_addr_low),
        .i_ram_data(i_ram_data),
        .i_fwd_mask(s2_fwd_mask),
        .i_fwd_data(s2_fwd_data),
        .o_result(s2_result)
    );

    // s3 writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            o_wb_vld <= 1'b0;
        end else begin
            o_wb_vld <= s2_vld;
        end
        o_wb_rob_idx <= s2_rob;
        o_wb_data <= (s2_is_load && !s2_mis) ? s2_result : '0;
        o_wb_misaligned <= s2_mis;
    end

endmodule

`default_nettype wire

// File: lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // operand, address and result width
    localparam int xlen = 64;
    localparam int xbytes = xlen / 8;

    typedef logic [xlen-1:0] xword_t;

    // byte enables inside one aligned doubleword
    typedef logic [xbytes-1:0] byte_mask_t;

    // tag handed back with every writeback
    typedef logic [4:0] rob_idx_t;

    // memory micro-ops, loads first then stores
    typedef enum logic [3:0] {
        lb,
        lh,
        lw,
        ld,
        lbu,
        lhu,
        lwu,
        sb,
        sh,
        sw,
        sd
    } mem_op_t;

endpackage

`default_nettype wire

// File: lsu_store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_store_buffer import lsu_pkg::*; #(
    parameter int SB_DEPTH = 4,
    parameter int MEM_WORDS = 64
) (
    input wire clk,
    input wire rst,
    input wire i_push,
    input wire xword_t i_push_addr,
    input wire byte_mask_t i_push_mask,
    input wire xword_t i_push_data,
    input wire xword_t i_lookup_addr,
    input wire i_drain_en,
    output byte_mask_t o_fwd_mask,
    output xword_t o_fwd_data,
    output logic [$clog2(SB_DEPTH+1)-1:0] o_count,
    output logic o_drain_vld,
    output xword_t o_drain_addr,
    output byte_mask_t o_drain_mask,
    output xword_t o_drain_data
);

    localparam int AW = $clog2(MEM_WORDS);
    localparam int PW = $clog2(SB_DEPTH);
    localparam int CW = $clog2(SB_DEPTH+1);

    // entries keep only the ram index, upper address bits wrap away
    logic [AW-1:0] ent_idx [SB_DEPTH];
    byte_mask_t ent_mask [SB_DEPTH];
    xword_t ent_data [SB_DEPTH];

    logic [PW-1:0] head;
    logic [PW-1:0] tail;
    logic [CW-1:0] count;
    logic [AW-1:0] lookup_idx;

    assign lookup_idx = i_lookup_addr[3 +: AW];
    assign o_count = count;

    always_ff @(posedge clk) begin
        if (i_push) begin
            ent_idx[tail] <= i_push_addr[3 +: AW];
            ent_mask[tail] <= i_push_mask;
            ent_data[tail] <= i_push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (i_push) begin
                tail <= (tail == PW'(SB_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (o_drain_vld) begin
                head <= (head == PW'(SB_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count <= count + CW'(i_push) - CW'(o_drain_vld);
        end
    end

    // walk oldest to youngest so the youngest match overwrites
    always_comb begin
        int slot;
        o_fwd_mask = '0;
        o_fwd_data = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            slot = int'(head) + i;
            if (slot >= SB_DEPTH) begin
                slot = slot - SB_DEPTH;
            end
            if (i < int'(count) && ent_idx[slot] == lookup_idx) begin
                for (int b = 0; b < xbytes; b++) begin
                    if (ent_mask[slot][b]) begin
                        o_fwd_mask[b] = 1'b1;
                        o_fwd_data[8*b +: 8] = ent_data[slot][8*b +: 8];
                    end
                end
            end
        end
    end

    // oldest entry goes out whenever the ram port is free
    assign o_drain_vld = (count != '0) && i_drain_en;
    assign o_drain_addr = xword_t'({ent_idx[head], 3'b000});
    assign o_drain_mask = ent_mask[head];
    assign o_drain_data = ent_data[head];

endmodule

`default_nettype wire

// File: lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

// two entries so that back-to-back stores can fill the buffer
module lsu_tb import lsu_pkg::*; #(
    parameter int SB_DEPTH = 2,
    parameter int MEM_WORDS = 64
);

    localparam int N_OPS = 400;
    localparam int BURST_START = 200;
    localparam int BURST_END = 240;
    localparam int MEM_BYTES = MEM_WORDS * 8;
    localparam int CLK_PERIOD = 10;
    // per op budget covers bubbles and stall cycles
    localparam int TIMEOUT_CYCLES = N_OPS * 4 + MEM_WORDS + 100;

    logic clk;
    logic rst;
    logic vld;
    mem_op_t op;
    xword_t src0;
    xword_t src1;
    xword_t st_data;
    rob_idx_t rob_idx;
    logic stall;
    logic wb_vld;
    rob_idx_t wb_rob;
    xword_t wb_data;
    logic wb_mis;

    logic [7:0] mem_model [MEM_BYTES];

    // expected writebacks, oldest first
    rob_idx_t q_rob [$];
    xword_t q_data [$];
    logic q_mis [$];
    int q_due [$];

    integer seed;
    int cyc = 0;
    int wb_count = 0;
    int burst_stalls;

    tb_clkgen u_clkgen (
        .clk(clk),
        .rst(rst)
    );

    lsu_top #(
        .SB_DEPTH(SB_DEPTH),
        .MEM_WORDS(MEM_WORDS)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .i_vld(vld),
        .i_op(op),
        .i_src0(src0),
        .i_src1(src1),
        .i_st_data(st_data),
        .i_rob_idx(rob_idx),
        .o_stall(stall),
        .o_wb_vld(wb_vld),
        .o_wb_rob_idx(wb_rob),
        .o_wb_data(wb_data),
        .o_wb_misaligned(wb_mis)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_rob(input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: rob index %0d, expected %0d",
                                     $time, got, exp));
        end
    endtask

    task automatic check_data(input xword_t got, input xword_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: data %h, expected %h (rob %0d)",
                                     $time, got, exp, wb_rob));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: misaligned %b, expected %b (rob %0d)",
                                     $time, got, exp, wb_rob));
        end
    endtask

    function automatic int draw_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic xword_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int access_size(input mem_op_t mop);
        case (mop)
            lb, lbu, sb: return 1;
            lh, lhu, sh: return 2;
            lw, lwu, sw: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic logic is_store(input mem_op_t mop);
        return mop inside {sb, sh, sw, sd};
    endfunction

    // little endian bytes from the model, then extension by op
    function automatic xword_t load_value(input mem_op_t mop, input int base);
        xword_t raw;
        int size;
        raw = '0;
        size = access_size(mop);
        for (int i = 0; i < size; i++) begin
            raw[8*i +: 8] = mem_model[base + i];
        end
        if (mop inside {lb, lh, lw} && raw[8*size-1]) begin
            for (int i = size; i < 8; i++) begin
                raw[8*i +: 8] = 8'hff;
            end
        end
        return raw;
    endfunction

    task automatic next_op(input int n);
        mem_op_t mop;
        int size;
        int offset;
        if (n >= BURST_START && n < BURST_END) begin
            mop = mem_op_t'(4'(7 + draw_below(4)));
        end else begin
            mop = mem_op_t'(4'(draw_below(11)));
        end
        size = access_size(mop);
        // mostly a small window so loads meet recent stores
        if (draw_below(4) == 0) begin
            offset = draw_below(MEM_BYTES);
        end else begin
            offset = draw_below(64);
        end
        offset = offset & ~(size - 1);
        if (size > 1 && draw_below(8) == 0) begin
            offset = offset | 1;
        end
        op = mop;
        // upper bits only change the part of the address that wraps away
        src0 = rand_word() & ~xword_t'(MEM_BYTES - 1);
        src1 = xword_t'(offset);
        st_data = rand_word();
        rob_idx = rob_idx_t'(n);
    endtask

    // op goes in at the coming edge, results are due three edges later
    task automatic record_accept();
        xword_t addr;
        int size;
        int base;
        logic mis;
        addr = src0 + src1;
        size = access_size(op);
        base = int'(addr & xword_t'(MEM_BYTES - 1));
        mis = (addr & xword_t'(size - 1)) != '0;
        q_rob.push_back(rob_idx);
        q_mis.push_back(mis);
        q_due.push_back(cyc + 4);
        if (mis || is_store(op)) begin
            q_data.push_back('0);
        end else begin
            q_data.push_back(load_value(op, base));
        end
        if (!mis && is_store(op)) begin
            for (int i = 0; i < size; i++) begin
                mem_model[base + i] = st_data[8*i +: 8];
            end
        end
    endtask

    initial begin
        vld = 1'b0;
        op = lb;
        src0 = '0;
        src1 = '0;
        st_data = '0;
        rob_idx = '0;
        seed = 26410;
        burst_stalls = 0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem_model[i] = 8'h00;
        end
        wait (rst == 1'b0);
        for (int n = 0; n < N_OPS; n++) begin
            @(posedge clk);
            #1;
            // occasional bubble outside the store burst
            if ((n < BURST_START || n >= BURST_END) && draw_below(8) == 0) begin
                vld = 1'b0;
                @(posedge clk);
                #1;
            end
            next_op(n);
            vld = 1'b1;
            @(negedge clk);
            while (stall) begin
                if (n >= BURST_START && n < BURST_END) begin
                    burst_stalls++;
                end
                @(negedge clk);
            end
            record_accept();
        end
        @(posedge clk);
        #1;
        vld = 1'b0;
        while (q_rob.size() != 0) begin
            @(negedge clk);
        end
        // a stray writeback in these cycles still trips the monitor
        repeat (5) @(negedge clk);
        if (wb_count != N_OPS) begin
            report_failure($sformatf("only %0d of %0d ops wrote back", wb_count, N_OPS));
        end else if (SB_DEPTH <= 3 && burst_stalls == 0) begin
            report_failure("the store burst never raised o_stall");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

    // outputs are sampled half a cycle after they change
    always @(negedge clk) begin
        if (!rst && wb_vld) begin
            if (q_rob.size() == 0) begin
                report_failure("writeback seen with no op outstanding");
            end else if (q_due[0] != cyc) begin
                report_failure($sformatf("writeback for rob %0d came at cycle %0d, not %0d",
                                         q_rob[0], cyc, q_due[0]));
            end else begin
                check_rob(wb_rob, q_rob.pop_front());
                check_data(wb_data, q_data.pop_front());
                check_flag(wb_mis, q_mis.pop_front());
                q_due.delete(0);
                wb_count++;
            end
        end else if (!rst && q_due.size() != 0 && q_due[0] <= cyc) begin
            report_failure($sformatf("no writeback for rob %0d at cycle %0d",
                                     q_rob[0], q_due[0]));
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        report_failure("watchdog timeout, the ops did not all complete");
    end

endmodule

`default_nettype wire

// File: lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter int SB_DEPTH = 4,
    parameter int MEM_WORDS = 64
) (
    input wire clk,
    input wire rst,
    input wire i_vld,
    input wire mem_op_t i_op,
    input wire xword_t i_src0,
    input wire xword_t i_src1,
    input wire xword_t i_st_data,
    input wire rob_idx_t i_rob_idx,
    output logic o_stall,
    output logic o_wb_vld,
    output rob_idx_t o_wb_rob_idx,
    output xword_t o_wb_data,
    output logic o_wb_misaligned
);

    localparam int CW = $clog2(SB_DEPTH+1);

    logic [CW-1:0] sb_count;
    logic push;
    xword_t push_addr;
    byte_mask_t push_mask;
    xword_t push_data;
    xword_t lookup_addr;
    byte_mask_t fwd_mask;
    xword_t fwd_data;
    logic rd_en;
    xword_t rd_addr;
    xword_t ram_data;
    logic drain_en;
    logic drain_vld;
    xword_t drain_addr;
    byte_mask_t drain_mask;
    xword_t drain_data;
    logic clear_done;

    lsu_load_pipe #(
        .SB_DEPTH(SB_DEPTH)
    ) u_pipe (
        .clk(clk),
        .rst(rst),
        .i_vld(i_vld),
        .i_op(i_op),
        .i_src0(i_src0),
        .i_src1(i_src1),
        .i_st_data(i_st_data),
        .i_rob_idx(i_rob_idx),
        .i_sb_count(sb_count),
        .i_ram_data(ram_data),
        .i_fwd_mask(fwd_mask),
        .i_fwd_data(fwd_data),
        .i_clear_done(clear_done),
        .o_stall(o_stall),
        .o_push(push),
        .o_push_addr(push_addr),
        .o_push_mask(push_mask),
        .o_push_data(push_data),
        .o_lookup_addr(lookup_addr),
        .o_rd_en(rd_en),
        .o_rd_addr(rd_addr),
        .o_drain_en(drain_en),
        .o_wb_vld(o_wb_vld),
        .o_wb_rob_idx(o_wb_rob_idx),
        .o_wb_data(o_wb_data),
        .o_wb_misaligned(o_wb_misaligned)
    );

    lsu_store_buffer #(
        .SB_DEPTH(SB_DEPTH),
        .MEM_WORDS(MEM_WORDS)
    ) u_store_buffer (
        .clk(clk),
        .rst(rst),
        .i_push(push),
        .i_push_addr(push_addr),
        .i_push_mask(push_mask),
        .i_push_data(push_data),
        .i_lookup_addr(lookup_addr),
        .i_drain_en(drain_en),
        .o_fwd_mask(fwd_mask),
        .o_fwd_data(fwd_data),
        .o_count(sb_count),
        .o_drain_vld(drain_vld),
        .o_drain_addr(drain_addr),
        .o_drain_mask(drain_mask),
        .o_drain_data(drain_data)
    );

    lsu_dcache_ram #(
        .MEM_WORDS(MEM_WORDS)
    ) u_ram (
        .clk(clk),
        .rst(rst),
        .i_rd_en(rd_en),
        .i_rd_addr(rd_addr),
        .i_wr_en(drain_vld),
        .i_wr_addr(drain_addr),
        .i_wr_mask(drain_mask),
        .i_wr_data(drain_data),
        .o_rd_data(ram_data),
        .o_clear_done(clear_done)
    );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD = 5,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: verilog.f
lsu_pkg.sv
lsu_addr_gen.sv
lsu_data_align.sv
lsu_store_buffer.sv
lsu_dcache_ram.sv
lsu_load_pipe.sv
lsu_top.sv
tb_clkgen.sv
lsu_checker.sv
lsu_tb.sv
